// ==== src.f ====
+incdir+.
warpPkg.sv
chipSelect.sv
refreshTimer.sv
dramController.sv
ioBridge.sv
cycleTerminator.sv
warpSe.sv
iobDeviceModel.sv
warpSeTb.sv

// ==== Bender.yml ====
package:
  name: warpSe

export_include_dirs:
  - .

sources:
  - warpPkg.sv
  - chipSelect.sv
  - refreshTimer.sv
  - dramController.sv
  - ioBridge.sv
  - cycleTerminator.sv
  - warpSe.sv
  - target: simulation
    files:
      - iobDeviceModel.sv
      - warpSeTb.sv

// ==== warpSeTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "warpSe_macros.svh"

module warpSeTb;
	localparam int kindNone = 0;
	localparam int kindRam = 1;
	localparam int kindRom = 2;
	localparam int kindIo = 3;
	// about 40 cpu cycles of up to 25 clocks plus two refresh waits and a wide margin
	localparam int cycleLimit = 4000;
	localparam int refreshGapMax = `REFRESH_INTERVAL + `REFRESH_URGENT + 8;

	logic fClk;
	logic reset;
	logic [23:1] addr;
	logic nAs, nUds, nLds, nWe;
	logic nDtack, nBerr;
	logic [11:0] ra;
	logic nRas, nCas, nLwe, nUwe, nOe, nRomOe;
	logic [23:1] iobAddr;
	logic nAsIob, rnwIob, nUdsIob, nLdsIob;
	logic nDtackIob, nBerrIob;

	logic [23:0] curAddr; // byte address of the running cpu cycle
	logic curWrite, curUds, curLds, curErr;
	int curKind;
	logic asSeen; // cpu cycle seen on the clock
	logic seenWrite, seenUds, seenLds; // last cycle as the clock saw it
	int seenKind;
	logic [25:0] slowQ[$]; // {write, uds, lds, addr} of posted slow cycles
	int ioIssued, iobDone, refreshCount, refreshGap, cycles;
	logic prevDtack, prevAsIob, prevRas, prevDtackIob, lastEndOk;
	integer seed = 32'hea08;

	warpSe dut (.*);

	iobDeviceModel mbDevice (
		.fClk(fClk),
		.reset(reset),
		.iobAddr(iobAddr),
		.nAsIob(nAsIob),
		.nDtackIob(nDtackIob),
		.nBerrIob(nBerrIob)
	);

	initial begin
		fClk = 1'b0;
		forever #20 fClk = ~fClk; // 40 ns period
	end

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	// address map
	function automatic int decodeKind(input logic [23:0] a);
		if (a < 24'h400000) return kindRam;
		else if (a < 24'h500000) return kindRom;
		else if (a < 24'h800000) return kindNone;
		else return kindIo;
	endfunction

	function automatic logic [11:0] rowOf(input logic [23:0] a);
		return {2'b00, a[21:12]};
	endfunction

	function automatic logic [11:0] colOf(input logic [23:0] a);
		return {1'b0, a[11:1]};
	endfunction

	always @(posedge fClk) begin
		asSeen <= !reset && !nAs;
		if (!nAs) begin
			seenWrite <= curWrite; // held over the dram tail after nAs rises
			seenUds <= curUds;
			seenLds <= curLds;
			seenKind <= curKind;
		end
	end

	// per-edge monitor for counters and the slow bus
	always @(posedge fClk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			reportFailure("timeout: the run did not finish within the cycle limit");
		end else if (!reset) begin
			if (prevRas && !nRas && !nCas) begin
				refreshCount++; // cas before ras
				refreshGap = 0;
			end else begin
				refreshGap++;
			end
			if (refreshGap > refreshGapMax) reportFailure("refresh did not come in time");
			if (prevAsIob && !nAsIob) begin
				if (slowQ.size() == 0) begin
					reportFailure("slow bus cycle with no i/o access pending");
				end else if (iobAddr != slowQ[0][22:0]) begin
					reportFailure($sformatf("mismatch iobAddr: expected %h got %h",
						slowQ[0][22:0], iobAddr));
				end else if (rnwIob != !slowQ[0][25]) begin
					reportFailure($sformatf("mismatch rnwIob: expected %h got %h",
						!slowQ[0][25], rnwIob));
				end else if ({nUdsIob, nLdsIob} != ~slowQ[0][24:23]) begin
					reportFailure($sformatf("mismatch nUdsIob/nLdsIob: expected %h got %h",
						~slowQ[0][24:23], {nUdsIob, nLdsIob}));
				end
				void'(slowQ.pop_front());
			end
			if (!prevAsIob && nAsIob) begin
				iobDone++;
				lastEndOk = !prevDtackIob; // ended by an acknowledge
			end
			if (prevDtack && !nDtack && curKind == kindIo) begin
				if (iobDone != (curWrite ? ioIssued - 1 : ioIssued)) begin
					reportFailure($sformatf("mismatch slow cycles done: expected %h got %h",
						curWrite ? ioIssued - 1 : ioIssued, iobDone));
				end else if (!curWrite && !lastEndOk) begin
					reportFailure("i/o read acknowledged without nDtackIob");
				end
			end
		end
		prevDtack = nDtack;
		prevAsIob = nAsIob;
		prevRas = nRas;
		prevDtackIob = nDtackIob;
	end

	aRamAck: assert property (@(posedge fClk) disable iff (reset)
		$fell(nDtack) && curKind == kindRam |-> !nCas)
		else reportFailure($sformatf("mismatch nCas: expected 0 got %h", $sampled(nCas)));
	aRow: assert property (@(posedge fClk) disable iff (reset)
		$fell(nRas) && nCas |-> ra == rowOf(curAddr))
		else reportFailure($sformatf("mismatch ra row: expected %h got %h",
			rowOf(curAddr), $sampled(ra)));
	aCol: assert property (@(posedge fClk) disable iff (reset)
		$fell(nCas) && !nRas |-> ra == colOf(curAddr))
		else reportFailure($sformatf("mismatch ra column: expected %h got %h",
			colOf(curAddr), $sampled(ra)));
	aWeOnWrite: assert property (@(posedge fClk) disable iff (reset)
		(!nLwe || !nUwe) |-> seenWrite && seenKind == kindRam
			&& (nLwe || seenLds) && (nUwe || seenUds))
		else reportFailure("write enable low without a matching ram write strobe");
	aWeAtAck: assert property (@(posedge fClk) disable iff (reset)
		$fell(nDtack) && curKind == kindRam && curWrite |-> {nUwe, nLwe} == ~{curUds, curLds})
		else reportFailure($sformatf("mismatch nUwe/nLwe: expected %h got %h",
			~{curUds, curLds}, $sampled({nUwe, nLwe})));
	aOeOnRead: assert property (@(posedge fClk) disable iff (reset)
		!nOe |-> seenKind == kindRam && !seenWrite)
		else reportFailure("dram output enable low without a ram read");
	aOeAtAck: assert property (@(posedge fClk) disable iff (reset)
		$fell(nDtack) && curKind == kindRam |-> nOe == curWrite)
		else reportFailure($sformatf("mismatch nOe: expected %h got %h",
			curWrite, $sampled(nOe)));
	aRomOe: assert property (@(posedge fClk) disable iff (reset)
		asSeen && curKind == kindRom |-> !nRomOe)
		else reportFailure("mismatch nRomOe: expected 0 got 1");
	aRomWait: assert property (@(posedge fClk) disable iff (reset)
		$rose(asSeen) && curKind == kindRom |-> ##(`ROM_WAIT) $fell(nDtack))
		else reportFailure("rom cycle not acknowledged after the rom wait states");
	aNoAckOnErr: assert property (@(posedge fClk) disable iff (reset)
		asSeen && curErr |-> nDtack)
		else reportFailure("mismatch nDtack: expected 1 got 0");
	aNoErrOnOk: assert property (@(posedge fClk) disable iff (reset)
		asSeen && !curErr |-> nBerr)
		else reportFailure("mismatch nBerr: expected 1 got 0");
	aBerrTime: assert property (@(posedge fClk) disable iff (reset)
		$rose(asSeen) && curKind == kindNone |-> ##1 $fell(nBerr))
		else reportFailure("unmapped cycle did not get nBerr one edge after the cycle start");
	aPosted: assert property (@(posedge fClk) disable iff (reset)
		$fell(nDtack) && curKind == kindIo && curWrite |-> !nAsIob)
		else reportFailure("posted i/o write not acknowledged before its slow cycle ended");

	task automatic cpuCycle(input logic [23:0] a, input logic write, input logic uds,
		input logic lds, input int gap);
		logic gotAck;
		logic gotErr;
		begin
			curAddr = a;
			curWrite = write;
			curUds = uds;
			curLds = lds;
			curKind = decodeKind(a);
			curErr = curKind == kindNone || (curKind == kindIo && !write && a >= 24'hF00000);
			if (curKind == kindIo) begin
				ioIssued++;
				slowQ.push_back({write, uds, lds, a[23:1]});
			end
			addr = a[23:1];
			nWe = !write;
			nUds = !uds;
			nLds = !lds;
			nAs = 1'b0;
			gotAck = 1'b0;
			gotErr = 1'b0;
			while (!gotAck && !gotErr) begin
				@(posedge fClk);
				gotAck = !nDtack;
				gotErr = !nBerr;
			end
			#5;
			nAs = 1'b1;
			nUds = 1'b1;
			nLds = 1'b1;
			nWe = 1'b1;
			if (gotErr != curErr) begin
				reportFailure($sformatf("mismatch nBerr at %h: expected %h got %h",
					a, !curErr, !gotErr));
			end else begin
				repeat (gap + 1) @(posedge fClk); // nAs high over at least one edge
				#5;
			end
		end
	endtask

	task automatic waitRefreshStart;
		begin
			@(posedge fClk);
			while (!(!nCas && nRas)) @(posedge fClk); // cas down first with ras still up
			#5;
		end
	endtask

	initial begin : stimulus
		logic [31:0] r;
		logic [23:0] a;
		reset = 1'b1;
		addr = '0;
		nAs = 1'b1;
		nUds = 1'b1;
		nLds = 1'b1;
		nWe = 1'b1;
		curAddr = '0;
		curWrite = 1'b0;
		curUds = 1'b0;
		curLds = 1'b0;
		curErr = 1'b0;
		curKind = kindNone;
		seenWrite = 1'b0;
		seenUds = 1'b0;
		seenLds = 1'b0;
		seenKind = kindNone;
		{ioIssued, iobDone, refreshCount, refreshGap, cycles} = '0;
		{prevDtack, prevAsIob, prevRas, prevDtackIob} = 4'hf;
		lastEndOk = 1'b0;
		repeat (2) @(posedge fClk);
		#5 reset = 1'b0;

		cpuCycle(24'h012344, 1, 1, 1, 3); // ram
		cpuCycle(24'h1FF002, 1, 0, 1, 3);
		cpuCycle(24'h3ABCDE, 1, 1, 0, 3);
		cpuCycle(24'h2468A0, 0, 1, 1, 3);
		cpuCycle(24'h400000, 0, 1, 1, 3); // rom
		cpuCycle(24'h4FFFFE, 0, 1, 0, 3);
		cpuCycle(24'h500000, 0, 1, 1, 3); // unmapped
		cpuCycle(24'h7FFFFE, 1, 1, 1, 3);
		cpuCycle(24'h800010, 1, 1, 1, 0); // posted writes issued back to back
		cpuCycle(24'h900020, 1, 0, 1, 3);
		cpuCycle(24'h8000A0, 0, 1, 1, 3); // read
		cpuCycle(24'hF00004, 0, 1, 1, 3); // read that ends in a bus error
		cpuCycle(24'hF80000, 1, 1, 1, 3); // write error is dropped
		waitRefreshStart();
		cpuCycle(24'h155554, 0, 1, 1, 3); // lands on a refresh
		waitRefreshStart();
		cpuCycle(24'h2AAAAA, 1, 1, 1, 3);

		repeat (12) begin
			r = $random(seed);
			case (r[1:0])
				2'd1: a = {4'h4, r[19:1], 1'b0};
				2'd2: a = {1'b1, r[22:1], 1'b0};
				default: a = {2'b00, r[21:1], 1'b0};
			endcase
			cpuCycle(a, r[24], r[25] | ~r[26], r[26], r[29:28]);
		end

		while (iobDone != ioIssued) @(posedge fClk); // let posted writes drain
		if (refreshCount < 2) begin
			reportFailure("fewer than two refresh cycles seen");
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== iobDeviceModel.sv ====
`timescale 1ns/1ps
`default_nettype none

module iobDeviceModel (
	input logic fClk,
	input logic reset,
	input logic [23:1] iobAddr,
	input logic nAsIob,
	output logic nDtackIob,
	output logic nBerrIob
);
	integer seed = 32'hea08;
	logic busy; // slow cycle seen, answer pending or given
	logic sAs;
	logic [23:1] sAddr;
	int waitCnt; // edges left before the answer

	initial begin
		nDtackIob = 1'b1;
		nBerrIob = 1'b1;
		busy = 1'b0;
		waitCnt = 0;
		forever begin
			@(posedge fClk);
			sAs = nAsIob;
			sAddr = iobAddr;
			#5;
			if (reset || sAs) begin
				nDtackIob = 1'b1; // strobe gone, release
				nBerrIob = 1'b1;
				busy = 1'b0;
			end else if (!busy) begin
				busy = 1'b1;
				waitCnt = {$random(seed)} % 4; // 1 to 4 cycles in all
			end else begin
				waitCnt = waitCnt - 1;
			end
			if (busy && waitCnt == 0) begin
				if ({sAddr, 1'b0} >= 24'hF00000) begin
					nBerrIob = 1'b0; // nothing answers up there
				end else begin
					nDtackIob = 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== warpSe.sv ====
`timescale 1ns/1ps
`default_nettype none

module warpSe (
	input logic fClk,
	input logic reset,
	input logic [23:1] addr, // cpu bus
	input logic nAs,
	input logic nUds,
	input logic nLds,
	input logic nWe,
	output logic nDtack,
	output logic nBerr,
	output logic [11:0] ra, // dram
	output logic nRas,
	output logic nCas,
	output logic nLwe,
	output logic nUwe,
	output logic nOe,
	output logic nRomOe, // boot rom
	output logic [23:1] iobAddr, // motherboard bus
	output logic nAsIob,
	output logic rnwIob,
	output logic nUdsIob,
	output logic nLdsIob,
	input logic nDtackIob,
	input logic nBerrIob
);
	import warpPkg::*;

	devSelect devSel; // decoded target
	logic busActive;
	logic busActiveDly;
	logic refReq;
	logic refUrg;
	logic refAck;
	logic ramReady;
	logic ioReady;
	logic ioError;

	chipSelect cs (
		.addr(addr[23:8]),
		.devSel(devSel)
	);

	refreshTimer refTimer (
		.fClk(fClk),
		.reset(reset),
		.refAck(refAck),
		.refReq(refReq),
		.refUrg(refUrg)
	);

	dramController ram (
		.fClk(fClk),
		.reset(reset),
		.busActive(busActive),
		.busActiveDly(busActiveDly),
		.devSel(devSel),
		.addr(addr[21:1]),
		.nWe(nWe),
		.nUds(nUds),
		.nLds(nLds),
		.refReq(refReq),
		.refUrg(refUrg),
		.refAck(refAck),
		.ramReady(ramReady),
		.ra(ra),
		.nRas(nRas),
		.nCas(nCas),
		.nLwe(nLwe),
		.nUwe(nUwe),
		.nOe(nOe)
	);

	ioBridge iob (
		.fClk(fClk),
		.reset(reset),
		.busActive(busActive),
		.busActiveDly(busActiveDly),
		.devSel(devSel),
		.addr(addr),
		.nWe(nWe),
		.nUds(nUds),
		.nLds(nLds),
		.nDtackIob(nDtackIob),
		.nBerrIob(nBerrIob),
		.ioReady(ioReady),
		.ioError(ioError),
		.iobAddr(iobAddr),
		.nAsIob(nAsIob),
		.rnwIob(rnwIob),
		.nUdsIob(nUdsIob),
		.nLdsIob(nLdsIob)
	);

	cycleTerminator fsb (
		.fClk(fClk),
		.reset(reset),
		.nAs(nAs),
		.devSel(devSel),
		.ramReady(ramReady),
		.ioReady(ioReady),
		.ioError(ioError),
		.busActive(busActive),
		.busActiveDly(busActiveDly),
		.nDtack(nDtack),
		.nBerr(nBerr),
		.nRomOe(nRomOe)
	);

endmodule

`default_nettype wire

// ==== cycleTerminator.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "warpSe_macros.svh"

module cycleTerminator (
	input logic fClk,
	input logic reset,
	input logic nAs,
	input warpPkg::devSelect devSel,
	input logic ramReady,
	input logic ioReady,
	input logic ioError,
	output logic busActive, // nAs sampled low
	output logic busActiveDly, // busActive one cycle late
	output logic nDtack,
	output logic nBerr,
	output logic nRomOe
);
	import warpPkg::*;

	localparam int romW = $clog2(`ROM_WAIT + 1);

	logic [romW-1:0] romCnt; // edges since busActive rose, saturating
	logic romDone;
	logic ackNow; // some target is ready
	logic errNow; // unmapped or failed i/o read

	assign romDone = devSel == devRom && romCnt == romW'(`ROM_WAIT - 1);
	assign ackNow = busActive && (romDone || ramReady || ioReady);
	assign errNow = busActive && (devSel == devNone || ioError);

	always_ff @(posedge fClk) begin
		if (reset) begin
			busActive <= 1'b0;
			busActiveDly <= 1'b0;
			romCnt <= '0;
			nRomOe <= 1'b1;
			nDtack <= 1'b1;
			nBerr <= 1'b1;
		end else begin
			busActive <= !nAs;
			busActiveDly <= busActive;
			nRomOe <= nAs || devSel != devRom; // same edge as busActive
			nDtack <= nAs || (nDtack && !ackNow); // held until nAs goes high
			nBerr <= nAs || (nBerr && !errNow);
			if (!busActive) begin
				romCnt <= '0;
			end else if (romCnt != romW'(`ROM_WAIT - 1)) begin
				romCnt <= romCnt + 1'b1;
			end
		end
	end

	aOneTermination: assert property (@(posedge fClk) disable iff (reset) !(!nDtack && !nBerr))
		else $error("nDtack and nBerr low together");

endmodule

`default_nettype wire

// ==== ioBridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module ioBridge (
	input logic fClk,
	input logic reset,
	input logic busActive,
	input logic busActiveDly,
	input warpPkg::devSelect devSel,
	input logic [23:1] addr,
	input logic nWe,
	input logic nUds,
	input logic nLds,
	input logic nDtackIob, // slow bus acknowledge
	input logic nBerrIob, // slow bus error
	output logic ioReady,
	output logic ioError,
	output logic [23:1] iobAddr,
	output logic nAsIob,
	output logic rnwIob,
	output logic nUdsIob,
	output logic nLdsIob
);
	import warpPkg::*;

	ioState state;
	logic ioSel; // cpu cycle targets i/o
	logic newIo; // first cycle of an i/o access
	logic ioPend; // access waiting behind a running slow cycle
	logic ioStart; // latch the cpu cycle now
	logic udsHold; // latched strobes, active low
	logic ldsHold;
	logic errHold; // slow cycle ended with bus error

	assign ioSel = busActive && devSel == devIo;
	assign newIo = ioSel && !busActiveDly;
	assign ioStart = state == ioIdle && (newIo || ioPend);

	always_ff @(posedge fClk) begin
		if (reset) begin
			ioPend <= 1'b0;
		end else if (!ioSel || ioStart) begin
			ioPend <= 1'b0;
		end else if (newIo) begin
			ioPend <= 1'b1; // back pressure, previous cycle still on the bus
		end
	end

	always_ff @(posedge fClk) begin
		if (ioStart) begin
			iobAddr <= addr;
			udsHold <= nUds;
			ldsHold <= nLds;
		end
		if (state == ioWait) begin
			errHold <= !nBerrIob; // last sample is the one that ends the wait
		end
	end

	always_ff @(posedge fClk) begin
		if (reset) begin
			state <= ioIdle;
			nAsIob <= 1'b1;
			rnwIob <= 1'b1;
			nUdsIob <= 1'b1;
			nLdsIob <= 1'b1;
			ioReady <= 1'b0;
			ioError <= 1'b0;
		end else begin
			if (!busActive) begin
				ioReady <= 1'b0;
				ioError <= 1'b0;
			end
			case (state)
				ioIdle: begin
					if (ioStart) begin
						state <= ioStrobe;
						rnwIob <= nWe;
						ioReady <= !nWe; // posted write, cpu is free at once
					end
				end
				ioStrobe: begin
					state <= ioWait;
					nAsIob <= 1'b0;
					nUdsIob <= udsHold;
					nLdsIob <= ldsHold;
				end
				ioWait: begin
					if (!nDtackIob || !nBerrIob) begin
						state <= ioRelease;
						nAsIob <= 1'b1;
						nUdsIob <= 1'b1;
						nLdsIob <= 1'b1;
					end
				end
				ioRelease: begin
					state <= ioIdle;
					rnwIob <= 1'b1;
					// only a read has a cpu waiting, write errors are lost
					if (rnwIob && busActive) begin
						ioReady <= !errHold;
						ioError <= errHold;
					end
				end
				default: state <= ioIdle;
			endcase
		end
	end

	aIdleQuiet: assert property (@(posedge fClk) disable iff (reset)
		state == ioIdle |-> nAsIob && nUdsIob && nLdsIob)
		else $error("slow bus strobes low while bridge idle");

	aReleaseAfterAck: assert property (@(posedge fClk) disable iff (reset)
		$rose(nAsIob) |-> $past(!nDtackIob || !nBerrIob))
		else $error("nAsIob released without slow bus acknowledge");

endmodule

`default_nettype wire

// ==== dramController.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "warpSe_macros.svh"

module dramController (
	input logic fClk,
	input logic reset,
	input logic busActive, // cpu cycle in progress
	input logic busActiveDly, // busActive one cycle late
	input warpPkg::devSelect devSel,
	input logic [21:1] addr,
	input logic nWe,
	input logic nUds,
	input logic nLds,
	input logic refReq,
	input logic refUrg,
	output logic refAck, // one cycle, refresh granted
	output logic ramReady, // cpu access reached cas
	output logic [11:0] ra, // multiplexed row/column
	output logic nRas,
	output logic nCas,
	output logic nLwe,
	output logic nUwe,
	output logic nOe
);
	import warpPkg::*;

	localparam int cntW = $clog2(`RAM_PRECHARGE + 2); // holds precharge and refresh counts

	dramState state;
	logic [cntW-1:0] cnt; // precharge / refresh hold down counter
	logic ramSel; // current cpu cycle targets dram
	logic newRam; // first cycle of a dram access
	logic ramPend; // access seen while the controller was busy
	logic cpuReq;

	assign ramSel = busActive && devSel == devRam;
	assign newRam = ramSel && !busActiveDly;
	assign cpuReq = newRam || ramPend;

	always_ff @(posedge fClk) begin
		if (reset) begin
			ramPend <= 1'b0;
		end else if (!ramSel) begin
			ramPend <= 1'b0;
		end else if (state == ramIdle && !refUrg) begin
			ramPend <= 1'b0; // access is taken on this edge
		end else if (newRam) begin
			ramPend <= 1'b1; // refresh or precharge still running
		end
	end

	// row tracks the bus while idle, column is loaded in the row state
	always_ff @(posedge fClk) begin
		if (state == ramIdle) begin
			ra <= {2'b00, addr[21:12]};
		end else if (state == ramRow) begin
			ra <= {1'b0, addr[11:1]};
		end
	end

	always_ff @(posedge fClk) begin
		if (reset) begin
			state <= ramIdle;
			cnt <= '0;
			refAck <= 1'b0;
			ramReady <= 1'b0;
			nRas <= 1'b1;
			nCas <= 1'b1;
			nLwe <= 1'b1;
			nUwe <= 1'b1;
			nOe <= 1'b1;
		end else begin
			refAck <= 1'b0; // pulse only
			case (state)
				ramIdle: begin
					// urgent refresh first, plain refresh only with no cpu waiting
					if (refUrg || (refReq && !cpuReq)) begin
						state <= refCas;
						nCas <= 1'b0; // cas before ras
						refAck <= 1'b1;
					end else if (cpuReq) begin
						state <= ramRow;
						nRas <= 1'b0; // ra gets the row on this edge
					end
				end
				ramRow: state <= ramCol; // column goes out
				ramCol: begin
					state <= ramCas;
					nCas <= 1'b0;
					nOe <= ~nWe; // reads enable the dram outputs
					nLwe <= nWe | nLds;
					nUwe <= nWe | nUds;
					ramReady <= 1'b1;
				end
				ramCas: begin
					if (!busActive) begin // cpu has finished the cycle
						state <= ramPrecharge;
						cnt <= cntW'(`RAM_PRECHARGE - 1);
						nRas <= 1'b1;
						nCas <= 1'b1;
						nOe <= 1'b1;
						nLwe <= 1'b1;
						nUwe <= 1'b1;
						ramReady <= 1'b0;
					end
				end
				refCas: begin
					state <= refRas;
					nRas <= 1'b0;
					cnt <= cntW'(1); // both strobes low for two cycles
				end
				refRas: begin
					if (cnt == '0) begin
						state <= refPrecharge;
						cnt <= cntW'(`RAM_PRECHARGE - 1);
						nRas <= 1'b1;
						nCas <= 1'b1;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				ramPrecharge, refPrecharge: begin
					if (cnt == '0) begin
						state <= ramIdle;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: state <= ramIdle;
			endcase
		end
	end

	// on a cpu access ras must already be down when cas drops
	aRasBeforeCas: assert property (@(posedge fClk) disable iff (reset)
		$fell(nCas) && state == ramCas |-> $past(!nRas) && !nRas)
		else $error("nCas fell before nRas in a cpu cycle");

	aWeOnlyInCas: assert property (@(posedge fClk) disable iff (reset)
		(!nLwe || !nUwe) |-> state == ramCas && !nCas && !nRas)
		else $error("write enable low outside ramCas");

endmodule

`default_nettype wire

// ==== refreshTimer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "warpSe_macros.svh"

module refreshTimer (
	input logic fClk,
	input logic reset,
	input logic refAck, // pulse from the dram controller, refresh started
	output logic refReq, // sticky until acked
	output logic refUrg // request has waited too long
);
	localparam int intW = $clog2(`REFRESH_INTERVAL);
	localparam int urgW = $clog2(`REFRESH_URGENT);

	logic [intW-1:0] intCnt; // free running interval count
	logic [urgW-1:0] urgCnt; // age of the pending request
	logic intWrap; // end of interval

	assign intWrap = intCnt == intW'(`REFRESH_INTERVAL - 1);

	always_ff @(posedge fClk) begin
		if (reset) begin
			intCnt <= '0;
		end else begin
			intCnt <= intWrap ? '0 : intCnt + 1'b1;
		end
	end

	always_ff @(posedge fClk) begin
		if (reset) begin
			refReq <= 1'b0;
			refUrg <= 1'b0;
			urgCnt <= '0;
		end else begin
			if (refAck) begin
				refReq <= 1'b0;
				refUrg <= 1'b0;
			end else if (refReq && urgCnt == urgW'(`REFRESH_URGENT - 1)) begin
				refUrg <= 1'b1; // escalate, beats a cpu access
			end
			if (intWrap) begin
				refReq <= 1'b1; // a new interval always requests
			end
			if (!refReq || refAck) begin
				urgCnt <= '0;
			end else if (!refUrg) begin
				urgCnt <= urgCnt + 1'b1;
			end
		end
	end

	aUrgNeedsReq: assert property (@(posedge fClk) disable iff (reset) refUrg |-> refReq)
		else $error("refUrg high without refReq");

endmodule

`default_nettype wire

// ==== chipSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module chipSelect (
	input logic [23:8] addr, // upper cpu address, 256 byte granules
	output warpPkg::devSelect devSel // decoded target
);
	import warpPkg::*;

	localparam logic [15:0] romBase = 16'h4000; // $400000
	localparam logic [15:0] gapBase = 16'h5000; // $500000, start of unmapped hole
	localparam logic [15:0] ioBase = 16'h8000; // $800000, upper half is i/o

	// ranges are contiguous, so an ordered compare gives one select only
	always_comb begin
		if (addr < romBase) begin
			devSel = devRam; // 4 mb dram
		end else if (addr < gapBase) begin
			devSel = devRom; // 1 mb boot rom
		end else if (addr < ioBase) begin
			devSel = devNone; // nothing answers here
		end else begin
			devSel = devIo; // replayed on the motherboard bus
		end
	end

endmodule

`default_nettype wire

// ==== warpPkg.sv ====
`default_nettype none

package warpPkg;

	// target of the current cpu address, one per address
	typedef enum logic [1:0] {
		devNone = 2'd0, // unmapped hole, ends in nBerr
		devRam  = 2'd1, // dram, $000000-$3fffff
		devRom  = 2'd2, // boot rom, $400000-$4fffff
		devIo   = 2'd3  // motherboard i/o, $800000 and up
	} devSelect;

	// dram sequencer, cpu path then cas-before-ras refresh path
	typedef enum logic [2:0] {
		ramIdle      = 3'd0, // free, arbitrating
		ramRow       = 3'd1, // row on ra, nRas low
		ramCol       = 3'd2, // column on ra
		ramCas       = 3'd3, // nCas low, cpu gets ready
		ramPrecharge = 3'd4, // ras precharge after a cpu access
		refCas       = 3'd5, // nCas low first
		refRas       = 3'd6, // nRas follows, both held
		refPrecharge = 3'd7  // ras precharge after refresh
	} dramState;

	// slow bus cycle of the i/o bridge
	typedef enum logic [1:0] {
		ioIdle    = 2'd0, // no slow cycle running
		ioStrobe  = 2'd1, // address set up, strobes go low next
		ioWait    = 2'd2, // waiting for nDtackIob or nBerrIob
		ioRelease = 2'd3  // strobes high for one cycle
	} ioState;

endpackage

`default_nettype wire

// ==== warpSe_macros.svh ====
`ifndef WARP_SE_MACROS_SVH
`define WARP_SE_MACROS_SVH

// rom access time in fClk edges after the cycle is seen
`define ROM_WAIT 3

// fClk cycles between two refresh requests
`define REFRESH_INTERVAL 128

// a request left waiting this long becomes urgent
`define REFRESH_URGENT 32

// ras precharge cycles after every dram cycle
`define RAM_PRECHARGE 2

`endif
